// File: common/multicore_pkg.sv
package multicore_pkg;

	// width of samples and results on the external buses.
	localparam int DATA_W = 31;

	// accumulator width with headroom for the batch sum and the core weight.
	localparam int ACC_W = DATA_W + 8;

	// up to sixteen cores can be tagged on the result bus.
	localparam int CORE_ID_W = 4;

	typedef struct packed {
		logic signed [DATA_W-1:0] value;
	} sample_t;

	typedef struct packed {
		logic [CORE_ID_W-1:0] core_id;
		logic signed [DATA_W-1:0] value;
	} result_t;

	// a core either collects samples or holds a finished result.
	typedef enum logic [0:0] {
		CORE_ACCUM,
		CORE_RESULT
	} core_state_e;

endpackage

// File: logic/reset_sequencer.sv
`timescale 1ns/100ps

module reset_sequencer #(
	parameter int NUM_CORES = 4,
	parameter int RELEASE_GAP = 9
) (
	input  logic clk,
	input  logic rst_n,
	output logic [NUM_CORES-1:0] core_run
);

	localparam int GAP_W = (RELEASE_GAP > 1) ? $clog2(RELEASE_GAP) : 1;
	localparam int STAGE_W = $clog2(NUM_CORES + 1);

	logic [GAP_W-1:0] gap_cnt;
	logic [STAGE_W-1:0] stage;
	logic all_released;

	assign all_released = (stage == STAGE_W'(NUM_CORES));

	// stage counts the released cores and stops once all of them run.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gap_cnt <= '0;
			stage <= '0;
		end else if (!all_released) begin
			if (gap_cnt == GAP_W'(RELEASE_GAP - 1)) begin
				gap_cnt <= '0;
				stage <= stage + 1'b1;
			end else begin
				gap_cnt <= gap_cnt + 1'b1;
			end
		end
	end

	// core k runs once k+1 stages have completed.
	for (genvar k = 0; k < NUM_CORES; k++) begin : g_run
		assign core_run[k] = (stage > STAGE_W'(k));
	end

	run_never_falls: assert property (
		@(posedge clk) disable iff (!rst_n)
		(core_run & $past(core_run)) == $past(core_run)
	);

endmodule

// File: core/neuron_core.sv
`timescale 1ns/100ps

module neuron_core #(
	parameter int TAPS = 4,
	parameter int CORE_ID = 0
) (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	input  logic take,
	input  multicore_pkg::sample_t sample,
	output logic req,
	output logic res_valid,
	input  logic grant,
	output logic signed [multicore_pkg::DATA_W-1:0] res_value
);

	import multicore_pkg::*;

	localparam int TAP_W = (TAPS > 1) ? $clog2(TAPS) : 1;

	// each core weights its batch sum by its own index plus one.
	localparam logic signed [ACC_W-1:0] WEIGHT = ACC_W'(CORE_ID + 1);

	localparam logic signed [ACC_W-1:0] SAT_MAX =
		{{(ACC_W - DATA_W + 1){1'b0}}, {(DATA_W - 1){1'b1}}};
	localparam logic signed [ACC_W-1:0] SAT_MIN =
		{{(ACC_W - DATA_W + 1){1'b1}}, {(DATA_W - 1){1'b0}}};

	core_state_e state;
	logic [TAP_W-1:0] tap_cnt;
	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] sum_next;
	logic signed [ACC_W-1:0] weighted;
	logic signed [DATA_W-1:0] sat_value;
	logic last_tap;

	assign req = run && (state == CORE_ACCUM);
	assign res_valid = (state == CORE_RESULT);
	assign last_tap = (tap_cnt == TAP_W'(TAPS - 1));

	// the incoming sample is sign extended into the accumulator.
	assign sum_next = acc + sample.value;
	assign weighted = sum_next * WEIGHT;

	always_comb begin
		if (weighted > SAT_MAX) begin
			sat_value = {1'b0, {(DATA_W - 1){1'b1}}};
		end else if (weighted < SAT_MIN) begin
			sat_value = {1'b1, {(DATA_W - 1){1'b0}}};
		end else begin
			sat_value = weighted[DATA_W-1:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= CORE_ACCUM;
			tap_cnt <= '0;
			acc <= '0;
		end else begin
			case (state)
				CORE_ACCUM: begin
					if (take) begin
						if (last_tap) begin
							tap_cnt <= '0;
							state <= CORE_RESULT;
						end else begin
							tap_cnt <= tap_cnt + 1'b1;
							acc <= sum_next;
						end
					end
				end
				CORE_RESULT: begin
					// the result has left through the arbiter, start a new batch.
					if (grant) begin
						acc <= '0;
						state <= CORE_ACCUM;
					end
				end
			endcase
		end
	end

	// the weighted result is captured together with the last sample.
	always_ff @(posedge clk) begin
		if (take && last_tap) begin
			res_value <= sat_value;
		end
	end

	take_needs_req: assert property (
		@(posedge clk) disable iff (!rst_n)
		take |-> req
	);

	grant_needs_result: assert property (
		@(posedge clk) disable iff (!rst_n)
		grant |-> res_valid
	);

endmodule

// File: logic/input_dispatch.sv
`timescale 1ns/100ps

module input_dispatch #(
	parameter int NUM_CORES = 4
) (
	input  logic in_valid,
	output logic in_ready,
	input  logic [NUM_CORES-1:0] req,
	output logic [NUM_CORES-1:0] take
);

	logic [NUM_CORES-1:0] sel;

	// the input can move as soon as any released core asks for data.
	assign in_ready = |req;

	// scanning from the top leaves the lowest requesting index selected.
	always_comb begin
		sel = '0;
		for (int i = NUM_CORES - 1; i >= 0; i--) begin
			if (req[i]) begin
				sel = '0;
				sel[i] = 1'b1;
			end
		end
	end

	assign take = in_valid ? sel : '0;

	// only one core may see each accepted sample, and only one that asked.
	take_onehot: assert #0 ($onehot0(take) && ((take & ~req) == '0));

endmodule

// File: logic/result_arbiter.sv
`timescale 1ns/100ps

module result_arbiter #(
	parameter int NUM_CORES = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [NUM_CORES-1:0] res_valid,
	input  logic signed [multicore_pkg::DATA_W-1:0] res_value [NUM_CORES],
	output logic [NUM_CORES-1:0] grant,
	output multicore_pkg::result_t out_data,
	output logic out_valid,
	input  logic out_ready
);

	import multicore_pkg::*;

	logic [NUM_CORES-1:0] sel_onehot;
	logic [CORE_ID_W-1:0] sel_id;
	logic signed [DATA_W-1:0] sel_value;
	logic load;

	// lowest waiting index wins, mirroring the priority chain on the input side.
	always_comb begin
		sel_onehot = '0;
		sel_id = '0;
		sel_value = '0;
		for (int i = NUM_CORES - 1; i >= 0; i--) begin
			if (res_valid[i]) begin
				sel_onehot = '0;
				sel_onehot[i] = 1'b1;
				sel_id = CORE_ID_W'(i);
				sel_value = res_value[i];
			end
		end
	end

	// the output stage refills while it drains, so results can go back to back.
	assign load = (|res_valid) && (!out_valid || out_ready);
	assign grant = load ? sel_onehot : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			out_data.core_id <= sel_id;
			out_data.value <= sel_value;
		end
	end

	out_hold_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data)
	);

endmodule

// File: logic/multicore_top.sv
`timescale 1ns/100ps

module multicore_top #(
	parameter int NUM_CORES = 4,
	parameter int TAPS = 4,
	parameter int RELEASE_GAP = 9
) (
	input  logic clk,
	input  logic rst_n,
	input  multicore_pkg::sample_t in_data,
	input  logic in_valid,
	output logic in_ready,
	output multicore_pkg::result_t out_data,
	output logic out_valid,
	input  logic out_ready
);

	import multicore_pkg::*;

	logic [NUM_CORES-1:0] core_run;
	logic [NUM_CORES-1:0] req;
	logic [NUM_CORES-1:0] take;
	logic [NUM_CORES-1:0] res_valid;
	logic [NUM_CORES-1:0] grant;
	logic signed [DATA_W-1:0] res_value [NUM_CORES];

	reset_sequencer #(
		.NUM_CORES  (NUM_CORES),
		.RELEASE_GAP(RELEASE_GAP)
	) i_reset_sequencer (
		.clk     (clk),
		.rst_n   (rst_n),
		.core_run(core_run)
	);

	// all cores see the same sample bus, take decides who keeps it.
	for (genvar g = 0; g < NUM_CORES; g++) begin : g_core
		neuron_core #(
			.TAPS   (TAPS),
			.CORE_ID(g)
		) i_neuron_core (
			.clk      (clk),
			.rst_n    (rst_n),
			.run      (core_run[g]),
			.take     (take[g]),
			.sample   (in_data),
			.req      (req[g]),
			.res_valid(res_valid[g]),
			.grant    (grant[g]),
			.res_value(res_value[g])
		);
	end

	input_dispatch #(
		.NUM_CORES(NUM_CORES)
	) i_input_dispatch (
		.in_valid(in_valid),
		.in_ready(in_ready),
		.req     (req),
		.take    (take)
	);

	result_arbiter #(
		.NUM_CORES(NUM_CORES)
	) i_result_arbiter (
		.clk      (clk),
		.rst_n    (rst_n),
		.res_valid(res_valid),
		.res_value(res_value),
		.grant    (grant),
		.out_data (out_data),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

// File: tests/tb_multicore.sv
`timescale 1ns/100ps

module tb_multicore;

	import multicore_pkg::*;

	localparam int NUM_CORES = 4;
	localparam int TAPS = 4;
	localparam int RELEASE_GAP = 9;
	localparam int WAIT_LIMIT = 500;
	localparam longint SAMPLE_MAX = (longint'(1) <<< (DATA_W - 1)) - 1;
	localparam longint SAMPLE_MIN = -SAMPLE_MAX - 1;

	logic clk;
	logic rst_n;
	sample_t in_data;
	logic in_valid;
	logic in_ready;
	result_t out_data;
	logic out_valid;
	logic out_ready;

	string test_name;
	logic [15:0] lfsr_state;

	// reference model state, stepped on the falling edge.
	int samples_taken;
	int edges_after_reset;
	int m_taps [NUM_CORES];
	longint m_sum [NUM_CORES];
	logic signed [DATA_W-1:0] m_res [NUM_CORES];
	logic [NUM_CORES-1:0] m_done;
	logic m_out_full;
	result_t m_out;
	result_t seen_q [$];

	multicore_top i_multicore_top (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_data  (in_data),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.out_data (out_data),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_on_failure(input string line);
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1, "stopped at the first failing check");
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_on_failure($sformatf("ERR %s: %s expected %b actual %b",
				test_name, what, expected, actual));
		end
	endtask

	task automatic check_result(input result_t expected, input result_t actual,
		input string what);
		if (actual !== expected) begin
			stop_on_failure($sformatf(
				"ERR %s: %s expected id %0d value %0d actual id %0d value %0d",
				test_name, what, expected.core_id, expected.value, actual.core_id,
				actual.value));
		end
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		if (actual != expected) begin
			stop_on_failure($sformatf("ERR %s: %s expected %0d actual %0d",
				test_name, what, expected, actual));
		end
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	task automatic random_bits(input int count, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic signed [DATA_W-1:0] saturate(input longint value);
		if (value > SAMPLE_MAX) begin
			return DATA_W'(SAMPLE_MAX);
		end else if (value < SAMPLE_MIN) begin
			return DATA_W'(SAMPLE_MIN);
		end
		return DATA_W'(value);
	endfunction

	// each accepted sample goes to the lowest requesting core, each waiting
	// result to the output stage when it is empty or drains this cycle.
	always @(negedge clk) begin : model_step
		logic [NUM_CORES-1:0] m_req;
		int take_idx;
		int grant_idx;
		if (!rst_n) begin
			check_bit("in_ready in reset", 1'b0, in_ready);
			check_bit("out_valid in reset", 1'b0, out_valid);
			for (int k = 0; k < NUM_CORES; k++) begin
				m_taps[k] = 0;
				m_sum[k] = 0;
			end
			m_done = '0;
			m_out_full = 1'b0;
			edges_after_reset = 0;
		end else begin
			take_idx = -1;
			grant_idx = -1;
			for (int k = NUM_CORES - 1; k >= 0; k--) begin
				m_req[k] = (edges_after_reset >= (k + 1) * RELEASE_GAP) && !m_done[k];
				if (m_req[k]) begin
					take_idx = k;
				end
				if (m_done[k]) begin
					grant_idx = k;
				end
			end
			check_bit("in_ready", |m_req, in_ready);
			check_bit("out_valid", m_out_full, out_valid);
			if (m_out_full) begin
				check_result(m_out, out_data, "out_data");
			end
			if (m_out_full && out_ready) begin
				seen_q.push_back(out_data);
				m_out_full = 1'b0;
			end
			if (grant_idx >= 0 && !m_out_full) begin
				m_out.core_id = CORE_ID_W'(grant_idx);
				m_out.value = m_res[grant_idx];
				m_out_full = 1'b1;
				m_done[grant_idx] = 1'b0;
			end
			if (in_valid && take_idx >= 0) begin
				m_sum[take_idx] = m_sum[take_idx] + longint'(in_data.value);
				m_taps[take_idx]++;
				samples_taken++;
				if (m_taps[take_idx] == TAPS) begin
					m_res[take_idx] = saturate((take_idx + 1) * m_sum[take_idx]);
					m_done[take_idx] = 1'b1;
					m_taps[take_idx] = 0;
					m_sum[take_idx] = 0;
				end
			end
			edges_after_reset++;
		end
	end

	task automatic step_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic send_sample(input logic signed [DATA_W-1:0] value);
		int base;
		int waited;
		base = samples_taken;
		waited = 0;
		in_data.value = value;
		in_valid = 1'b1;
		while (samples_taken == base) begin
			step_cycle();
			waited++;
			if (waited > WAIT_LIMIT) begin
				stop_on_failure($sformatf("timeout in %s, the sample was never accepted",
					test_name));
			end
		end
		in_valid = 1'b0;
	endtask

	task automatic send_batch(input longint first, input longint step);
		for (int i = 0; i < TAPS; i++) begin
			send_sample(DATA_W'(first + i * step));
		end
	endtask

	task automatic wait_out_valid();
		int waited;
		waited = 0;
		while (!out_valid) begin
			step_cycle();
			waited++;
			if (waited > WAIT_LIMIT) begin
				stop_on_failure($sformatf("timeout in %s, out_valid never rose", test_name));
			end
		end
	endtask

	task automatic wait_results(input int target);
		int waited;
		waited = 0;
		while (seen_q.size() < target) begin
			step_cycle();
			waited++;
			if (waited > WAIT_LIMIT) begin
				stop_on_failure($sformatf("timeout in %s, %0d results arrived of %0d",
					test_name, seen_q.size(), target));
			end
		end
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		while (m_out_full || m_done != '0) begin
			step_cycle();
			waited++;
			if (waited > WAIT_LIMIT) begin
				stop_on_failure($sformatf("timeout in %s, results never drained", test_name));
			end
		end
	endtask

	task automatic test_reset_release();
		test_name = "reset_release";
		rst_n = 1'b0;
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			check_bit("in_ready", 1'b0, in_ready);
			check_bit("out_valid", 1'b0, out_valid);
		end
		step_cycle();
		rst_n = 1'b1;
		for (int i = 0; i < RELEASE_GAP; i++) begin
			@(negedge clk);
			check_bit("in_ready", 1'b0, in_ready);
			check_bit("out_valid", 1'b0, out_valid);
		end
		@(negedge clk);
		check_bit("in_ready", 1'b1, in_ready);
	endtask

	task automatic test_core_order();
		int start;
		int core;
		longint sum;
		result_t expected;
		test_name = "core_order";
		repeat (NUM_CORES * RELEASE_GAP) step_cycle();
		start = seen_q.size();
		out_ready = 1'b0;
		send_batch(-3, 2);
		wait_out_valid();
		for (int b = 1; b <= NUM_CORES; b++) begin
			send_batch(b * 16 - 3, 2);
		end
		out_ready = 1'b1;
		wait_results(start + NUM_CORES + 1);
		for (int b = 0; b <= NUM_CORES; b++) begin
			// core 0 empties into the output stage and takes the second batch too.
			core = (b == 0) ? 0 : b - 1;
			sum = 0;
			for (int i = 0; i < TAPS; i++) begin
				sum = sum + b * 16 - 3 + 2 * i;
			end
			expected.core_id = CORE_ID_W'(core);
			expected.value = saturate((core + 1) * sum);
			check_result(expected, seen_q[start + b], "batch result");
		end
	endtask

	task automatic test_saturation();
		int start;
		result_t expected;
		test_name = "saturation";
		start = seen_q.size();
		out_ready = 1'b1;
		send_batch(SAMPLE_MAX, 0);
		wait_results(start + 1);
		expected.core_id = '0;
		expected.value = DATA_W'(SAMPLE_MAX);
		check_result(expected, seen_q[start], "positive limit");
		send_batch(SAMPLE_MIN, 0);
		wait_results(start + 2);
		expected.value = DATA_W'(SAMPLE_MIN);
		check_result(expected, seen_q[start + 1], "negative limit");
	endtask

	task automatic test_back_pressure();
		int start;
		int accepted;
		test_name = "back_pressure";
		start = seen_q.size();
		accepted = 0;
		out_ready = 1'b0;
		in_data.value = DATA_W'(-50);
		in_valid = 1'b1;
		// in_ready follows registered state only, so a high value means a transfer next edge.
		while (in_ready) begin
			step_cycle();
			accepted++;
			in_data.value = DATA_W'(accepted * 37 - 50);
			if (accepted > WAIT_LIMIT) begin
				stop_on_failure($sformatf("timeout in %s, in_ready stayed high", test_name));
			end
		end
		in_valid = 1'b0;
		// every core holds a result and the output stage holds one more.
		check_count("accepted samples", (NUM_CORES + 1) * TAPS, accepted);
		for (int i = 0; i < 4; i++) begin
			step_cycle();
			check_bit("in_ready while stalled", 1'b0, in_ready);
		end
		out_ready = 1'b1;
		wait_results(start + NUM_CORES + 1);
		check_bit("in_ready after drain", 1'b1, in_ready);
	endtask

	task automatic test_random_rounds(input int rounds);
		int total;
		int sent;
		int base;
		int stalled;
		logic [31:0] bits;
		test_name = "random_rounds";
		total = rounds * NUM_CORES * TAPS;
		base = samples_taken;
		sent = 0;
		stalled = 0;
		while (sent < total) begin
			if (!in_valid) begin
				random_bits(20, bits);
				in_data.value = {{(DATA_W - 20){bits[19]}}, bits[19:0]};
				in_valid = 1'b1;
			end
			random_bits(1, bits);
			out_ready = bits[0];
			step_cycle();
			stalled++;
			if (samples_taken - base > sent) begin
				sent++;
				stalled = 0;
				in_valid = 1'b0;
			end
			if (stalled > WAIT_LIMIT) begin
				stop_on_failure($sformatf("timeout in %s, input stalled", test_name));
			end
		end
		in_valid = 1'b0;
		out_ready = 1'b1;
		wait_idle();
	endtask

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		out_ready = 1'b0;
		lfsr_state = 16'd82;
		samples_taken = 0;
		test_reset_release();
		test_core_order();
		test_saturation();
		test_back_pressure();
		test_random_rounds(3);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: tb.f
common/multicore_pkg.sv
logic/reset_sequencer.sv
core/neuron_core.sv
logic/input_dispatch.sv
logic/result_arbiter.sv
logic/multicore_top.sv
tests/tb_multicore.sv
